// File: Makefile
# Verilator flow for the light-cycle arena
# The testbench top is tronArena_tb, the RTL top level is tronArena

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module tronArena -f compile.f

sim:
	verilator --binary --timing --assert --top-module tronArena_tb -f compile.f -o simTron
	./obj_dir/simTron | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
hdl/tronPkg.sv
hdl/lightCycle.sv
hdl/arenaReferee.sv
hdl/tronArena.sv
test/tronArena_assert.sv
test/tronArena_tb.sv

// File: hdl/arenaReferee.sv
// Arena referee
// Collision checks, trail memory, plot sequencing, clear sweep and BCD scoring
`timescale 1ns/1ns

module arenaReferee (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            step,
    input  logic                            newRound,
    input  logic [tronPkg::CoordXWidth-1:0] head1X,
    input  logic [tronPkg::CoordYWidth-1:0] head1Y,
    input  logic [tronPkg::CoordXWidth-1:0] head2X,
    input  logic [tronPkg::CoordYWidth-1:0] head2Y,
    output logic                            advance,
    output logic                            regroup,
    output logic                            plot,
    output logic [tronPkg::CoordXWidth-1:0] plotX,
    output logic [tronPkg::CoordYWidth-1:0] plotY,
    output logic [2:0]                      plotColour,
    output logic                            roundOver,
    output tronPkg::bcdScoreT               score1,
    output tronPkg::bcdScoreT               score2
);

    // One bit per raster cell, set where a head has been drawn
    logic trail [tronPkg::GridWidth][tronPkg::GridHeight];

    logic [2:0] state;
    logic [2:0] stateNext;
    logic roundOverNext;
    logic plotNext;
    logic [tronPkg::CoordXWidth-1:0] xNext;
    logic [tronPkg::CoordYWidth-1:0] yNext;
    logic [2:0] colourNext;
    logic credit1;
    logic credit2;
    logic crash1;
    logic crash2;

    // Sweep position, y is the inner count
    logic [tronPkg::CoordXWidth-1:0] sweepX;
    logic [tronPkg::CoordYWidth-1:0] sweepY;
    logic sweepLast;

    // Counts one BCD step and wraps 99 back to 00
    function automatic tronPkg::bcdScoreT bcdInc(input tronPkg::bcdScoreT value);
        logic [3:0] tens;
        logic [3:0] ones;
        tens = value[7:4];
        ones = value[3:0];
        if (ones == 4'd9) begin
            ones = 4'd0;
            tens = (tens == 4'd9) ? 4'd0 : tens + 4'd1;
        end else begin
            ones = ones + 4'd1;
        end
        return {tens, ones};
    endfunction

    // True on or beyond any of the four walls
    function automatic logic onWall(input logic [tronPkg::CoordXWidth-1:0] x,
                                    input logic [tronPkg::CoordYWidth-1:0] y);
        return (x <= tronPkg::WallXLeft) || (x >= tronPkg::WallXRight) ||
               (y <= tronPkg::WallYTop) || (y >= tronPkg::WallYBottom);
    endfunction

    // Player 1 also loses on a head-on meeting, so player 2 never needs that test
    assign crash1 = onWall(head1X, head1Y) || trail[head1X][head1Y] ||
                    ((head1X == head2X) && (head1Y == head2Y));
    assign crash2 = onWall(head2X, head2Y) || trail[head2X][head2Y];

    assign sweepLast = (sweepX == tronPkg::WallXRight - 1'b1) &&
                       (sweepY == tronPkg::WallYBottom - 1'b1);

    // Both cycles move in the single Advancing cycle and sit at start while the board clears
    assign advance = (state == tronPkg::PhaseAdvancing);
    assign regroup = (state == tronPkg::PhaseClearing);

    always_comb begin
        stateNext = state;
        roundOverNext = roundOver;
        plotNext = 1'b0;
        xNext = sweepX;
        yNext = sweepY;
        colourNext = tronPkg::ColourBlack;
        credit1 = 1'b0;
        credit2 = 1'b0;
        if (newRound && !roundOver) begin
            // A forced restart wipes the board without crediting anyone
            stateNext = tronPkg::PhaseClearing;
            roundOverNext = 1'b1;
        end else begin
            case (state)
                tronPkg::PhaseIdle: begin
                    // roundOver is still up for one cycle after the last sweep plot
                    if (roundOver) begin
                        roundOverNext = 1'b0;
                    end else if (step) begin
                        stateNext = tronPkg::PhaseAdvancing;
                    end
                end
                tronPkg::PhaseAdvancing: begin
                    stateNext = tronPkg::PhaseCheck1;
                end
                tronPkg::PhaseCheck1: begin
                    if (crash1) begin
                        stateNext = tronPkg::PhaseClearing;
                        roundOverNext = 1'b1;
                        credit2 = 1'b1;
                    end else begin
                        plotNext = 1'b1;
                        xNext = head1X;
                        yNext = head1Y;
                        colourNext = tronPkg::ColourPlayer1;
                        stateNext = tronPkg::PhaseCheck2;
                    end
                end
                tronPkg::PhaseCheck2: begin
                    // The trail already holds player 1's cell from this step
                    if (crash2) begin
                        stateNext = tronPkg::PhaseClearing;
                        roundOverNext = 1'b1;
                        credit1 = 1'b1;
                    end else begin
                        plotNext = 1'b1;
                        xNext = head2X;
                        yNext = head2Y;
                        colourNext = tronPkg::ColourPlayer2;
                        stateNext = tronPkg::PhaseIdle;
                    end
                end
                default: begin
                    // Clearing plots one black cell per clock until the far corner
                    plotNext = 1'b1;
                    if (sweepLast) begin
                        stateNext = tronPkg::PhaseIdle;
                    end
                end
            endcase
        end
    end

    // Control registers
    // After reset the referee starts by clearing the board
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= tronPkg::PhaseClearing;
            roundOver <= 1'b1;
            plot <= 1'b0;
            plotColour <= tronPkg::ColourBlack;
            score1 <= '0;
            score2 <= '0;
            sweepX <= tronPkg::WallXLeft + 1'b1;
            sweepY <= tronPkg::WallYTop + 1'b1;
        end else begin
            state <= stateNext;
            roundOver <= roundOverNext;
            plot <= plotNext;
            plotColour <= colourNext;
            if (credit1) begin
                score1 <= bcdInc(score1);
            end
            if (credit2) begin
                score2 <= bcdInc(score2);
            end
            if (state == tronPkg::PhaseClearing) begin
                if (sweepY == tronPkg::WallYBottom - 1'b1) begin
                    sweepY <= tronPkg::WallYTop + 1'b1;
                    sweepX <= sweepLast ? tronPkg::WallXLeft + 1'b1 : sweepX + 1'b1;
                end else begin
                    sweepY <= sweepY + 1'b1;
                end
            end
        end
    end

    // Pixel coordinates and trail memory
    // Every plot writes the trail, head plots set their bit and sweep plots clear it
    always_ff @(posedge clk) begin
        plotX <= xNext;
        plotY <= yNext;
        if (plotNext) begin
            trail[xNext][yNext] <= (colourNext != tronPkg::ColourBlack);
        end
    end

endmodule

// File: hdl/lightCycle.sv
// One light cycle
// Steering FSM with the reference turn rules and the head-position register
`timescale 1ns/1ns

module lightCycle #(
    parameter logic [tronPkg::CoordXWidth-1:0] StartX = tronPkg::Start1X
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            advance,
    input  logic                            regroup,
    input  logic [3:0]                      steer,
    output logic [tronPkg::CoordXWidth-1:0] headX,
    output logic [tronPkg::CoordYWidth-1:0] headY
);

    tronPkg::headingT heading;
    tronPkg::headingT headingNext;

    // Turn tables
    // A request is honoured only when it crosses the current axis
    // Steer is one-hot, so anything with more than one bit set falls to the default
    always_comb begin
        headingNext = heading;
        case (heading.dir)
            tronPkg::North, tronPkg::South: begin
                // Travelling vertically, only East or West can be taken
                case (steer)
                    4'b0001: headingNext.dir = tronPkg::East;
                    4'b1000: headingNext.dir = tronPkg::West;
                    default: headingNext = heading;
                endcase
            end
            default: begin
                // Travelling horizontally, only North or South can be taken
                case (steer)
                    4'b0010: headingNext.dir = tronPkg::North;
                    4'b0100: headingNext.dir = tronPkg::South;
                    default: headingNext = heading;
                endcase
            end
        endcase
    end

    // The heading follows the steer inputs on every clock, not only on advance
    always_ff @(posedge clk) begin
        if (!resetn || regroup) begin
            heading.dir <= tronPkg::North;
        end else begin
            heading <= headingNext;
        end
    end

    // Position stepper
    // Uses the axis and sign view of the heading to pick one coordinate and nudge it
    always_ff @(posedge clk) begin
        if (!resetn || regroup) begin
            headX <= StartX;
            headY <= tronPkg::StartY;
        end else if (advance) begin
            if (heading.move.vertical) begin
                // Screen rows grow downwards, so North counts y down
                if (heading.move.negative) begin
                    headY <= headY - 1'b1;
                end else begin
                    headY <= headY + 1'b1;
                end
            end else begin
                if (heading.move.negative) begin
                    headX <= headX - 1'b1;
                end else begin
                    headX <= headX + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/tronArena.sv
// Light-cycle arena top level
// Two steered cycles and the referee that checks, plots and scores them
`timescale 1ns/1ns

module tronArena (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            step,
    input  logic                            newRound,
    input  logic [3:0]                      steer1,
    input  logic [3:0]                      steer2,
    output logic                            plot,
    output logic [tronPkg::CoordXWidth-1:0] plotX,
    output logic [tronPkg::CoordYWidth-1:0] plotY,
    output logic [2:0]                      plotColour,
    output logic                            roundOver,
    output tronPkg::bcdScoreT               score1,
    output tronPkg::bcdScoreT               score2
);

    // Move strobe and start-cell hold from the referee to both cycles
    logic advance;
    logic regroup;

    logic [tronPkg::CoordXWidth-1:0] head1X;
    logic [tronPkg::CoordYWidth-1:0] head1Y;
    logic [tronPkg::CoordXWidth-1:0] head2X;
    logic [tronPkg::CoordYWidth-1:0] head2Y;

    // Player 1 starts on the left
    lightCycle #(.StartX(tronPkg::Start1X)) cycle1 (
        .clk(clk), .resetn(resetn), .advance(advance), .regroup(regroup),
        .steer(steer1), .headX(head1X), .headY(head1Y)
    );

    // Player 2 starts on the right
    lightCycle #(.StartX(tronPkg::Start2X)) cycle2 (
        .clk(clk), .resetn(resetn), .advance(advance), .regroup(regroup),
        .steer(steer2), .headX(head2X), .headY(head2Y)
    );

    arenaReferee referee (
        .clk(clk), .resetn(resetn), .step(step), .newRound(newRound),
        .head1X(head1X), .head1Y(head1Y), .head2X(head2X), .head2Y(head2Y),
        .advance(advance), .regroup(regroup), .plot(plot), .plotX(plotX),
        .plotY(plotY), .plotColour(plotColour), .roundOver(roundOver),
        .score1(score1), .score2(score2)
    );

endmodule

// File: hdl/tronPkg.sv
// Shared definitions for the light-cycle arena
// Arena geometry, start cells, colours, referee phase codes and the heading and score types
package tronPkg;

    // Coordinate widths match a 160 by 120 pixel raster
    localparam int CoordXWidth = 8;
    localparam int CoordYWidth = 7;

    // Wall cells, a head on any of these crashes
    localparam logic [CoordXWidth-1:0] WallXLeft = 8'd10;
    localparam logic [CoordXWidth-1:0] WallXRight = 8'd149;
    localparam logic [CoordYWidth-1:0] WallYTop = 7'd17;
    localparam logic [CoordYWidth-1:0] WallYBottom = 7'd108;

    // Trail memory covers the whole raster
    localparam int GridWidth = 160;
    localparam int GridHeight = 120;

    // Both cycles start on the same row near the bottom wall
    localparam logic [CoordXWidth-1:0] Start1X = 8'd25;
    localparam logic [CoordXWidth-1:0] Start2X = 8'd135;
    localparam logic [CoordYWidth-1:0] StartY = 7'd100;

    // Three-bit RGB pixel colours
    localparam logic [2:0] ColourBlack = 3'd0;
    localparam logic [2:0] ColourPlayer1 = 3'd1;
    localparam logic [2:0] ColourPlayer2 = 3'd4;

    // Referee phases
    localparam logic [2:0] PhaseIdle = 3'd0;
    localparam logic [2:0] PhaseAdvancing = 3'd1;
    localparam logic [2:0] PhaseCheck1 = 3'd2;
    localparam logic [2:0] PhaseCheck2 = 3'd3;
    localparam logic [2:0] PhaseClearing = 3'd4;

    // Heading codes are chosen so that the bits also read as axis and sign
    typedef enum logic [1:0] {East = 2'b00, West = 2'b01, South = 2'b10, North = 2'b11} dirT;

    typedef struct packed {
        logic vertical;
        logic negative;
    } moveT;

    // The steering FSM reads dir while the stepper reads move
    typedef union packed {
        dirT dir;
        moveT move;
    } headingT;

    // Two BCD digits, tens in the upper nibble
    typedef logic [7:0] bcdScoreT;

endpackage

// File: test/tronArena_assert.sv
// Concurrent assertions for the arena referee
// Bound into every arenaReferee instance
`timescale 1ns/1ns

module tronArenaAssert (
    input logic       clk,
    input logic       resetn,
    input logic       plot,
    input logic       roundOver,
    input logic       advance,
    input logic       regroup,
    input logic [2:0] plotColour
);

    // While the round is over the only plots are the black sweep plots
    plotWhileOver: assert property (@(posedge clk) disable iff (!resetn)
        (plot && roundOver) |-> (plotColour == tronPkg::ColourBlack))
        else $error("A coloured plot was made while the round was over");

    // The move strobe lasts a single cycle
    advanceOneCycle: assert property (@(posedge clk) disable iff (!resetn)
        advance |=> !advance)
        else $error("advance stayed high for more than one cycle");

    // Both cycles are held at start only while the board is swept black
    blackDuringRegroup: assert property (@(posedge clk) disable iff (!resetn)
        regroup |-> (plotColour == tronPkg::ColourBlack))
        else $error("plotColour was not black while regroup was high");

endmodule

bind arenaReferee tronArenaAssert refereeChecks (
    .clk(clk),
    .resetn(resetn),
    .plot(plot),
    .roundOver(roundOver),
    .advance(advance),
    .regroup(regroup),
    .plotColour(plotColour)
);

// File: test/tronArena_tb.sv
// Testbench for the light-cycle arena top level
// Golden-file driven steps, sweep and plot checks, and a watchdog
`timescale 1ns/1ns

module tronArena_tb;

    localparam int ClockPeriod = 100;
    localparam int DriveDelay = 5;
    localparam int ResetCycles = 10;
    // The sweep covers every cell strictly inside the walls
    localparam int SweepRows = int'(tronPkg::WallYBottom) - int'(tronPkg::WallYTop) - 1;
    localparam int SweepColumns = int'(tronPkg::WallXRight) - int'(tronPkg::WallXLeft) - 1;
    localparam int SweepPlots = SweepRows * SweepColumns;

    // One golden line without its name
    typedef struct packed {
        int newRound;
        logic [3:0] steer1;
        logic [3:0] steer2;
        int steps;
        int p1X;
        int p1Y;
        int p2X;
        int p2Y;
        logic [7:0] score1;
        logic [7:0] score2;
        int roundOver;
    } goldenRowT;

    logic clk;
    logic resetn;
    logic step;
    logic newRound;
    logic [3:0] steer1;
    logic [3:0] steer2;
    logic plot;
    logic [tronPkg::CoordXWidth-1:0] plotX;
    logic [tronPkg::CoordYWidth-1:0] plotY;
    logic [2:0] plotColour;
    logic roundOver;
    tronPkg::bcdScoreT score1;
    tronPkg::bcdScoreT score2;

    goldenRowT rows[$];
    string names[$];
    string currentTest;
    int watchdogCycles;
    // Last head plot seen in each player colour
    int last1X;
    int last1Y;
    int last2X;
    int last2Y;
    // Scores expected after the previous golden line
    logic [7:0] expScore1;
    logic [7:0] expScore2;

    tronArena i_dut (
        .clk(clk),
        .resetn(resetn),
        .step(step),
        .newRound(newRound),
        .steer1(steer1),
        .steer2(steer2),
        .plot(plot),
        .plotX(plotX),
        .plotY(plotY),
        .plotColour(plotColour),
        .roundOver(roundOver),
        .score1(score1),
        .score2(score2)
    );

    initial begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    task automatic haltRun();
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic checkValue(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("FAILED %s %s: expected %0d, actual %0d", currentTest, what, expected, actual);
            haltRun();
        end
    endtask

    task automatic checkBcd(input string what, input logic [7:0] expected,
                            input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", currentTest, what, expected, actual);
            haltRun();
        end
    endtask

    // Keeps the last coloured plot of each player from any cycle
    task automatic recordPlot();
        if (plot === 1'b1) begin
            if (plotColour == tronPkg::ColourPlayer1) begin
                last1X = int'(plotX);
                last1Y = int'(plotY);
            end else if (plotColour == tronPkg::ColourPlayer2) begin
                last2X = int'(plotX);
                last2Y = int'(plotY);
            end
        end
    endtask

    // Outputs are sampled and inputs driven a little after each rising edge
    task automatic nextEdge();
        @(posedge clk);
        #DriveDelay;
        recordPlot();
    endtask

    task automatic readGolden();
        int fd;
        int fields;
        string line;
        string name;
        int col [11];
        goldenRowT row;
        fd = $fopen("test/tron_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file test/tron_golden.txt");
            haltRun();
        end
        while ($fgets(line, fd) != 0) begin
            // Comment and blank lines never scan to a full row
            if (line.substr(0, 1) != "//") begin
                fields = $sscanf(line, "%s %d %h %h %d %d %d %d %d %h %h %d", name, col[0],
                                 col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                                 col[8], col[9], col[10]);
                if (fields == 12) begin
                    row.newRound = col[0];
                    row.steer1 = col[1][3:0];
                    row.steer2 = col[2][3:0];
                    row.steps = col[3];
                    row.p1X = col[4];
                    row.p1Y = col[5];
                    row.p2X = col[6];
                    row.p2Y = col[7];
                    row.score1 = col[8][7:0];
                    row.score2 = col[9][7:0];
                    row.roundOver = col[10];
                    rows.push_back(row);
                    names.push_back(name);
                end
            end
        end
        $fclose(fd);
        if (rows.size() == 0) begin
            $display("The golden file holds no test lines");
            haltRun();
        end
    endtask

    // Follows a clear sweep from its first black plot until roundOver falls
    task automatic runSweep();
        int count;
        int expX;
        int expY;
        count = 0;
        // Both players let go of the controls while the board is cleared
        steer1 = 4'b0000;
        steer2 = 4'b0000;
        nextEdge();
        while (roundOver) begin
            expX = int'(tronPkg::WallXLeft) + 1 + count / SweepRows;
            expY = int'(tronPkg::WallYTop) + 1 + count % SweepRows;
            checkValue("sweep plot", 1, int'(plot));
            checkValue("sweep colour", int'(tronPkg::ColourBlack), int'(plotColour));
            checkValue("sweep x", expX, int'(plotX));
            checkValue("sweep y", expY, int'(plotY));
            count++;
            nextEdge();
        end
        checkValue("sweep plot count", SweepPlots, count);
        checkValue("plot after sweep", 0, int'(plot));
    endtask

    // One move with the plot timing fixed at two and three edges after the step
    task automatic runStep(input bit crash1, input bit crash2);
        step = 1'b1;
        nextEdge();
        step = 1'b0;
        checkValue("plot at advance", 0, int'(plot));
        nextEdge();
        checkValue("plot at head move", 0, int'(plot));
        nextEdge();
        checkValue("roundOver after player 1 check", int'(crash1), int'(roundOver));
        if (crash1) begin
            checkValue("plot on player 1 crash", 0, int'(plot));
        end else begin
            checkValue("player 1 plot", 1, int'(plot));
            checkValue("player 1 colour", int'(tronPkg::ColourPlayer1), int'(plotColour));
            nextEdge();
            checkValue("roundOver after player 2 check", int'(crash2), int'(roundOver));
            if (crash2) begin
                checkValue("plot on player 2 crash", 0, int'(plot));
            end else begin
                checkValue("player 2 plot", 1, int'(plot));
                checkValue("player 2 colour", int'(tronPkg::ColourPlayer2), int'(plotColour));
            end
        end
    endtask

    task automatic runLine(input int idx);
        goldenRowT row;
        bit crash1;
        bit crash2;
        int n;
        row = rows[idx];
        currentTest = names[idx];
        crash1 = 1'b0;
        crash2 = 1'b0;
        // Steering settles into the heading before the first step
        steer1 = row.steer1;
        steer2 = row.steer2;
        nextEdge();
        if (row.newRound != 0) begin
            newRound = 1'b1;
            nextEdge();
            newRound = 1'b0;
        end else begin
            for (n = 0; n < row.steps; n++) begin
                // Only the last step of a round-ending line crashes
                // The credited score tells which player crashed
                if ((n == row.steps - 1) && (row.roundOver != 0)) begin
                    crash1 = (row.score2 != expScore2);
                    crash2 = (row.score1 != expScore1);
                end
                runStep(crash1, crash2);
            end
        end
        checkValue("player 1 x", row.p1X, last1X);
        checkValue("player 1 y", row.p1Y, last1Y);
        checkValue("player 2 x", row.p2X, last2X);
        checkValue("player 2 y", row.p2Y, last2Y);
        checkBcd("score1", row.score1, score1);
        checkBcd("score2", row.score2, score2);
        checkValue("roundOver", row.roundOver, int'(roundOver));
        expScore1 = row.score1;
        expScore2 = row.score2;
        if (row.roundOver != 0) begin
            runSweep();
        end
    endtask

    // Watchdog sized from the sweep length and the steps in the golden file
    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished", watchdogCycles);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation timed out");
    end

    initial begin
        int totalSteps;
        int rounds;
        resetn = 1'b0;
        step = 1'b0;
        newRound = 1'b0;
        steer1 = 4'b0000;
        steer2 = 4'b0000;
        watchdogCycles = 0;
        last1X = -1;
        last1Y = -1;
        last2X = -1;
        last2Y = -1;
        expScore1 = 8'h00;
        expScore2 = 8'h00;
        readGolden();
        totalSteps = 0;
        rounds = 1;
        foreach (rows[i]) begin
            totalSteps += rows[i].steps;
            if (rows[i].roundOver != 0) begin
                rounds++;
            end
        end
        watchdogCycles = (SweepPlots + 4 * totalSteps + 4 * rows.size()) * rounds + 1000;

        // The board starts with a sweep once reset is released
        currentTest = "reset";
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        checkValue("roundOver in reset", 1, int'(roundOver));
        checkValue("plot in reset", 0, int'(plot));
        checkBcd("score1 in reset", 8'h00, score1);
        checkBcd("score2 in reset", 8'h00, score2);
        resetn = 1'b1;
        currentTest = "resetSweep";
        runSweep();
        checkBcd("score1 after sweep", 8'h00, score1);
        checkBcd("score2 after sweep", 8'h00, score2);

        foreach (rows[i]) begin
            runLine(i);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: test/tron_golden.txt
// name newRound steer1 steer2 steps p1X p1Y p2X p2Y score1 score2 roundOver
// Steer is one-hot hex (8 West, 4 South, 2 North, 1 East), scores are BCD hex, pN is the last plot
move          0 0 0  1 25 99 135 99 00 00 0
steerEast     0 1 0  3 28 99 135 96 00 00 0
southIgnored  0 0 4  2 30 99 135 94 00 00 0
twoBits       0 6 9  2 32 99 135 92 00 00 0
turnNorth     0 2 0  1 32 98 135 91 00 00 0
wallCrash     0 8 0 22 11 98 135 70 00 01 1
restart       0 0 0  1 25 99 135 99 00 01 0
p2North       0 0 0  2 25 97 135 97 00 01 0
p2East        0 0 1  1 25 96 136 97 00 01 0
p2South       0 0 4  1 25 95 136 98 00 01 0
trailCrash    0 0 8  1 25 94 136 98 01 01 1
nextRound     0 0 0  1 25 99 135 99 01 01 0
newRound      1 0 0  0 25 99 135 99 01 01 1
afterNewRound 0 0 0  3 25 97 135 97 01 01 0
